/* run.sh */
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_top -f verilog.f -o tb_sim

out=$(./obj_dir/tb_sim || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

/* src/fetch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_control
  import y86_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        start,
  input  wire logic [63:0] start_pc,
  input  wire logic        redirect_en,
  input  wire logic [63:0] redirect_pc,
  input  fetch_rec_t       next_rec,
  output logic [63:0]      pc,
  output fetch_rec_t       rec,
  output logic             rec_valid,
  output logic             running
);

  // pc the stage moves to after this cycle
  logic [63:0] pc_next;

  // external redirect beats the sequential successor
  assign pc_next = redirect_en ? redirect_pc : next_rec.valp;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc        <= '0;
      running   <= 1'b0;
      rec_valid <= 1'b0;
      rec       <= '0;
    end
    else
    begin
      // one record per running cycle
      rec_valid <= running;
      if (running)
      begin
        rec <= next_rec;
        pc  <= pc_next;
        // halt, ins or adr: emit it, then stop
        if (next_rec.stat != AOK)
        begin
          running <= 1'b0;
        end
      end
      else if (start)
      begin
        // idle, so start loads the first pc
        pc      <= start_pc;
        running <= 1'b1;
      end
    end
  end

  // each record belongs to a cycle in which the stage was running
  rec_needs_run: assert property (
    @(posedge clk) disable iff (rst)
    rec_valid |-> $past(running)
  ) else $error("fetch_control: rec_valid without a running cycle before it");

  // a start while running must not reload the pc
  start_ignored: assert property (
    @(posedge clk) disable iff (rst)
    (start && running) |=> (pc == $past(pc_next))
  ) else $error("fetch_control: start took effect while running");

  // the record shows the pc that was held one cycle earlier
  rec_pc_follows: assert property (
    @(posedge clk) disable iff (rst)
    rec_valid |-> (rec.pc == $past(pc))
  ) else $error("fetch_control: record pc does not match the fetched pc");

endmodule

`default_nettype wire

/* src/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "y86_settings.svh"

module instr_decode
  import y86_pkg::*;
(
  input  wire logic [63:0] pc,
  input  instr_window_t    window,
  output fetch_rec_t       next_rec
);

  // first address past the end of memory
  localparam logic [63:0] MEM_END = 64'(`IMEM_BYTES);

  // opcode view of the upper nibble
  icode_e op;

  // per-instruction properties
  logic [3:0] ilen;
  logic       has_regs;
  logic       valc_at1;
  logic       valc_at2;
  logic       bad_op;

  assign op = icode_e'(window.byte0[7:4]);

  // instruction class lookup
  always_comb
  begin
    ilen     = 4'd1;
    has_regs = 1'b0;
    valc_at1 = 1'b0;
    valc_at2 = 1'b0;
    bad_op   = 1'b0;
    case (op)
      HALT, NOP, RET:
      begin
        ilen = 4'd1;
      end
      CMOVXX, OPQ, PUSHQ, POPQ:
      begin
        ilen     = 4'd2;
        has_regs = 1'b1;
      end
      IRMOVQ, RMMOVQ, MRMOVQ:
      begin
        // reg byte then 8 byte constant
        ilen     = 4'd10;
        has_regs = 1'b1;
        valc_at2 = 1'b1;
      end
      JXX, CALL:
      begin
        // destination follows the opcode directly
        ilen     = 4'd9;
        valc_at1 = 1'b1;
      end
      default:
      begin
        // codes 12..15
        bad_op = 1'b1;
      end
    endcase
  end

  // build the record
  always_comb
  begin
    next_rec    = '0;
    next_rec.pc = pc;
    if (pc >= MEM_END)
    begin
      // out of range pc, only pc and stat carry data
      next_rec.stat = ADR;
      next_rec.valp = pc;
    end
    else
    begin
      next_rec.icode = window.byte0[7:4];
      next_rec.ifun  = window.byte0[3:0];
      next_rec.ra    = RNONE;
      next_rec.rb    = RNONE;
      if (has_regs)
      begin
        next_rec.ra = window.byte1[7:4];
        next_rec.rb = window.byte1[3:0];
      end
      // constants read with the first byte most significant
      if (valc_at2)
      begin
        next_rec.valc = {window.byte2, window.byte3, window.byte4, window.byte5,
                         window.byte6, window.byte7, window.byte8, window.byte9};
      end
      else if (valc_at1)
      begin
        next_rec.valc = {window.byte1, window.byte2, window.byte3, window.byte4,
                         window.byte5, window.byte6, window.byte7, window.byte8};
      end
      if (bad_op)
      begin
        // no length known, valp stays at pc
        next_rec.stat = INS;
        next_rec.valp = pc;
      end
      else
      begin
        next_rec.stat = (op == HALT) ? HLT : AOK;
        next_rec.valp = pc + 64'(ilen);
      end
    end
  end

endmodule

`default_nettype wire

/* src/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "y86_settings.svh"

module instr_mem
  import y86_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          load_en,
  input  wire logic [9:0]    load_addr,
  input  wire logic [7:0]    load_data,
  input  wire logic [63:0]   pc,
  output instr_window_t      window
);

  // address bits of the byte array
  localparam int AW = $clog2(`IMEM_BYTES);

  // first address past the end of memory
  localparam logic [63:0] MEM_END = 64'(`IMEM_BYTES);

  // program bytes, kept across reset
  logic [7:0] mem [`IMEM_BYTES];

  // window before the struct cast
  logic [`INSTR_MAX_BYTES*8-1:0] win_flat;

  // load port, one byte per clock
  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      mem[load_addr] <= load_data;
    end
  end

  // read window at the pc
  // byte i comes from pc+i, zero once past the end
  always_comb
  begin : win_read
    logic [63:0] byte_addr;
    win_flat = '0;
    for (int i = 0; i < `INSTR_MAX_BYTES; i++)
    begin
      byte_addr = pc + 64'(i);
      if (byte_addr < MEM_END)
      begin
        // byte0 lands in the top bits
        win_flat[(`INSTR_MAX_BYTES-1-i)*8 +: 8] = mem[byte_addr[AW-1:0]];
      end
    end
  end

  assign window = instr_window_t'(win_flat);

  // a load must never hit an unknown address
  // otherwise the program image is silently corrupt
  load_addr_known: assert property (
    @(posedge clk) disable iff (rst)
    load_en |-> !$isunknown(load_addr)
  ) else $error("instr_mem: load with unknown load_addr");

endmodule

`default_nettype wire

/* src/y86_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module y86_fetch_top
  import y86_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        load_en,
  input  wire logic [9:0]  load_addr,
  input  wire logic [7:0]  load_data,
  input  wire logic        start,
  input  wire logic [63:0] start_pc,
  input  wire logic        redirect_en,
  input  wire logic [63:0] redirect_pc,
  output fetch_rec_t       rec,
  output logic             rec_valid,
  output logic             running
);

  // current fetch address from control
  logic [63:0] pc;

  // raw bytes at the pc
  instr_window_t window;

  // decoded record, not yet registered
  fetch_rec_t next_rec;

  // program storage and byte window
  instr_mem i_mem (
    .clk       (clk),
    .rst       (rst),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .window    (window)
  );

  // field split, valp and status
  instr_decode i_decode (
    .pc       (pc),
    .window   (window),
    .next_rec (next_rec)
  );

  // pc, run state, output register
  fetch_control i_control (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .start_pc    (start_pc),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .next_rec    (next_rec),
    .pc          (pc),
    .rec         (rec),
    .rec_valid   (rec_valid),
    .running     (running)
  );

endmodule

`default_nettype wire

/* src/y86_pkg.sv */
`default_nettype none

package y86_pkg;

  // y86-64 instruction codes, upper nibble of byte0
  // codes 12 to 15 are not defined
  typedef enum logic [3:0] {
    HALT   = 4'h0,
    NOP    = 4'h1,
    CMOVXX = 4'h2,
    IRMOVQ = 4'h3,
    RMMOVQ = 4'h4,
    MRMOVQ = 4'h5,
    OPQ    = 4'h6,
    JXX    = 4'h7,
    CALL   = 4'h8,
    RET    = 4'h9,
    PUSHQ  = 4'hA,
    POPQ   = 4'hB
  } icode_e;

  // fetch status, adr wins over the rest
  typedef enum logic [1:0] {
    AOK = 2'd0,
    HLT = 2'd1,
    ADR = 2'd2,
    INS = 2'd3
  } stat_e;

  // register field for an unused operand
  localparam logic [3:0] RNONE = 4'hF;

  // ten bytes starting at the pc
  // byte0 sits in the top bits
  typedef struct packed {
    logic [7:0] byte0;
    logic [7:0] byte1;
    logic [7:0] byte2;
    logic [7:0] byte3;
    logic [7:0] byte4;
    logic [7:0] byte5;
    logic [7:0] byte6;
    logic [7:0] byte7;
    logic [7:0] byte8;
    logic [7:0] byte9;
  } instr_window_t;

  // one decoded instruction as seen by the next stage
  typedef struct packed {
    logic [63:0] pc;
    logic [3:0]  icode;
    logic [3:0]  ifun;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [63:0] valc;
    logic [63:0] valp;
    stat_e       stat;
  } fetch_rec_t;

endpackage

`default_nettype wire

/* src/y86_settings.svh */
`ifndef Y86_SETTINGS_SVH
`define Y86_SETTINGS_SVH

// instruction memory size in bytes
// valid fetch addresses run 0 .. IMEM_BYTES-1
`define IMEM_BYTES 1024

// longest y86-64 instruction
// irmovq, rmmovq and mrmovq take this many bytes
// also the width of the read window at the pc
`define INSTR_MAX_BYTES 10

`endif

/* test/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "y86_settings.svh"

module tb_checker
  import y86_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        load_en,
  input  wire logic [9:0]  load_addr,
  input  wire logic [7:0]  load_data,
  input  wire logic        start,
  input  wire logic [63:0] start_pc,
  input  wire logic        redirect_en,
  input  wire logic [63:0] redirect_pc,
  input  fetch_rec_t       rec,
  input  wire logic        rec_valid,
  input  wire logic        running,
  output int               value_errs,
  output int               strobe_errs,
  output int               rec_count
);

  // copy of every byte written through the load port
  logic [7:0] shadow [`IMEM_BYTES];

  // model state, advanced on the rising edge
  logic        armed = 1'b0;
  logic        in_rst = 1'b0;
  logic        m_running = 1'b0;
  logic [63:0] m_pc = '0;
  logic        exp_valid = 1'b0;
  fetch_rec_t  exp_rec = '0;

  // counters, written only by the compare block
  int n_value = 0;
  int n_strobe = 0;
  int n_rec = 0;

  assign value_errs  = n_value;
  assign strobe_errs = n_strobe;
  assign rec_count   = n_rec;

  // past the end of memory reads as zero
  function automatic logic [7:0] byte_at(input logic [63:0] a);
    if (a >= 64'(`IMEM_BYTES))
      return 8'h00;
    return shadow[a[9:0]];
  endfunction

  // expected record for one pc
  function automatic fetch_rec_t ref_decode(input logic [63:0] pc);
    fetch_rec_t r;
    logic [7:0] b0;
    logic [7:0] b1;
    int len;
    int c0;
    r = '0;
    r.pc = pc;
    r.valp = pc;
    r.stat = ADR;
    if (pc >= 64'(`IMEM_BYTES))
      return r;
    b0 = byte_at(pc);
    b1 = byte_at(pc + 64'd1);
    r.icode = b0[7:4];
    r.ifun = b0[3:0];
    r.ra = RNONE;
    r.rb = RNONE;
    // len 0 marks an undefined code, c0 is where valc starts
    len = 0;
    c0 = 0;
    case (icode_e'(b0[7:4]))
      HALT, NOP, RET:
        len = 1;
      CMOVXX, OPQ, PUSHQ, POPQ:
        len = 2;
      JXX, CALL:
      begin
        len = 9;
        c0 = 1;
      end
      IRMOVQ, RMMOVQ, MRMOVQ:
      begin
        len = 10;
        c0 = 2;
      end
      default:
        len = 0;
    endcase
    // register byte only when it is not the start of the constant
    if (len >= 2 && c0 != 1)
    begin
      r.ra = b1[7:4];
      r.rb = b1[3:0];
    end
    // first constant byte ends up most significant
    if (c0 != 0)
      for (int k = 0; k < 8; k++)
        r.valc = {r.valc[55:0], byte_at(pc + 64'(c0 + k))};
    if (len == 0)
      r.stat = INS;
    else
    begin
      r.stat = (b0[7:4] == 4'h0) ? HLT : AOK;
      r.valp = pc + 64'(len);
    end
    return r;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want)
    begin
      n_value++;
      $display("FAIL %0d ns: %s at pc %0h is %0h, expected %0h",
               $time, name, exp_rec.pc, got, want);
    end
  endtask

  // inputs are stable here, they change on the falling edge
  always @(posedge clk)
  begin
    in_rst = rst;
    if (rst)
    begin
      armed = 1'b1;
      m_running = 1'b0;
      exp_valid = 1'b0;
      exp_rec = '0;
    end
    else
    begin
      exp_valid = m_running;
      if (m_running)
      begin
        exp_rec = ref_decode(m_pc);
        m_pc = redirect_en ? redirect_pc : exp_rec.valp;
        // a non-aok record is the last of the run
        if (exp_rec.stat != AOK)
          m_running = 1'b0;
      end
      else if (start)
      begin
        m_pc = start_pc;
        m_running = 1'b1;
      end
      // memory reads above see the bytes before this write
      if (load_en)
        shadow[load_addr] = load_data;
    end
  end

  // outputs settled half a period after the rising edge
  always @(negedge clk)
  begin
    if (armed)
    begin
      if (rec_valid !== exp_valid)
      begin
        n_strobe++;
        if (exp_valid)
          $display("missing record at %0d ns, no rec_valid for pc %0h", $time, exp_rec.pc);
        else
          $display("unexpected rec_valid at %0d ns with no record due", $time);
      end
      if (running !== m_running)
      begin
        n_strobe++;
        $display("running is %b at %0d ns but should be %b", running, $time, m_running);
      end
      if (in_rst && rec !== '0)
      begin
        n_value++;
        $display("FAIL %0d ns: record not cleared by reset", $time);
      end
      if (exp_valid && rec_valid === 1'b1)
      begin
        n_rec++;
        check_field("pc", rec.pc, exp_rec.pc);
        check_field("icode", 64'(rec.icode), 64'(exp_rec.icode));
        check_field("ifun", 64'(rec.ifun), 64'(exp_rec.ifun));
        check_field("ra", 64'(rec.ra), 64'(exp_rec.ra));
        check_field("rb", 64'(rec.rb), 64'(exp_rec.rb));
        check_field("valc", rec.valc, exp_rec.valc);
        check_field("valp", rec.valp, exp_rec.valp);
        check_field("stat", 64'(rec.stat), 64'(exp_rec.stat));
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  // 40 ns clock period
  localparam int HALF_NS = 20;

  initial
  begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  // reset over two rising edges, released on a falling edge
  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* test/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "y86_settings.svh"

module tb_top
  import y86_pkg::*;
();

  // programs 0..2 are directed, the rest random
  localparam int NUM_PROGS  = 32;
  localparam int LOAD_MAX   = `IMEM_BYTES;
  localparam int RUN_CYCLES = 400;
  localparam longint WATCHDOG_NS =
    longint'(NUM_PROGS) * longint'(LOAD_MAX + RUN_CYCLES) * 40;

  logic        clk;
  logic        rst;
  logic        load_en;
  logic [9:0]  load_addr;
  logic [7:0]  load_data;
  logic        start;
  logic [63:0] start_pc;
  logic        redirect_en;
  logic [63:0] redirect_pc;
  fetch_rec_t  rec;
  logic        rec_valid;
  logic        running;
  int          value_errs;
  int          strobe_errs;
  int          rec_count;

  // xorshift state and the program image being built
  logic [31:0] rng = 32'h1008;
  logic [7:0]  prog [$];

  tb_clock i_clock (
    .clk (clk),
    .rst (rst)
  );

  y86_fetch_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .start       (start),
    .start_pc    (start_pc),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .rec         (rec),
    .rec_valid   (rec_valid),
    .running     (running)
  );

  tb_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .start       (start),
    .start_pc    (start_pc),
    .redirect_en (redirect_en),
    .redirect_pc (redirect_pc),
    .rec         (rec),
    .rec_valid   (rec_valid),
    .running     (running),
    .value_errs  (value_errs),
    .strobe_errs (strobe_errs),
    .rec_count   (rec_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // bytes per instruction, undefined codes get one
  function automatic int encoded_len(input logic [3:0] code);
    case (code)
      4'h2, 4'h6, 4'hA, 4'hB: return 2;
      4'h3, 4'h4, 4'h5: return 10;
      4'h7, 4'h8: return 9;
      default: return 1;
    endcase
  endfunction

  // opcode byte, then random register and constant bytes
  task automatic append_instr(input logic [3:0] code);
    logic [31:0] r;
    r = rand32();
    prog.push_back({code, r[3:0]});
    for (int k = 1; k < encoded_len(code); k++)
    begin
      r = rand32();
      prog.push_back(r[7:0]);
    end
  endtask

  // random body, ended by halt or an undefined code
  task automatic build_random_program();
    logic [31:0] r;
    prog.delete();
    r = rand32();
    for (int n = 0; n < 3 + int'(r % 32'd10); n++)
      append_instr(4'(32'd1 + rand32() % 32'd11));
    r = rand32();
    append_instr(r[0] ? 4'h0 : 4'(32'd12 + r[9:8]));
  endtask

  task automatic load_program(input int base);
    foreach (prog[i])
    begin
      @(negedge clk);
      load_en = 1'b1;
      load_addr = 10'(base + i);
      load_data = prog[i];
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // undefined icodes everywhere, so a stray fetch stops with ins
  task automatic fill_memory();
    logic [9:0] a;
    for (int i = 0; i < `IMEM_BYTES; i++)
    begin
      @(negedge clk);
      a = 10'(i);
      load_en = 1'b1;
      load_addr = a;
      load_data = {2'b11, a[5:0] ^ {2'b00, a[9:6]}};
    end
    @(negedge clk);
    load_en = 1'b0;
  endtask

  // start, then random redirects and stray starts until running drops
  task automatic run_program(input logic [63:0] pc0, input int lo, input int span,
                             input bit jumps);
    logic [31:0] r;
    int redirects;
    redirects = 0;
    @(negedge clk);
    start = 1'b1;
    start_pc = pc0;
    @(negedge clk);
    start = 1'b0;
    while (running)
    begin
      r = rand32();
      start = 1'b0;
      redirect_en = 1'b0;
      redirect_pc = {rand32(), rand32()};
      if (jumps && r[2:0] == 3'd0 && redirects < 16)
      begin
        redirects++;
        redirect_en = 1'b1;
        if (r[6:3] == 4'd0)
          redirect_pc = 64'(`IMEM_BYTES) + 64'(r[31:20]);
        else
          redirect_pc = 64'(lo + (int'(r >> 8) % span));
      end
      if (jumps && r[11:8] == 4'd0)
      begin
        start = 1'b1;
        start_pc = {rand32(), rand32()};
      end
      @(negedge clk);
    end
    start = 1'b0;
    // redirect while idle does nothing
    redirect_en = 1'b1;
    redirect_pc = 64'(lo);
    @(negedge clk);
    redirect_en = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  initial
  begin
    int base;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    start = 1'b0;
    start_pc = '0;
    redirect_en = 1'b0;
    redirect_pc = '0;
    wait (!rst);
    @(negedge clk);
    // quiet after reset, nothing started yet
    repeat (4) @(negedge clk);
    fill_memory();
    for (int p = 0; p < NUM_PROGS; p++)
    begin
      prog.delete();
      if (p == 0)
      begin
        // each defined icode once, straight line
        for (int c = 1; c < 12; c++)
          append_instr(4'(c));
        append_instr(4'h0);
        load_program(16);
        run_program(64'd16, 16, prog.size(), 1'b0);
      end
      else if (p == 1)
      begin
        // irmovq cut off by the end of memory
        append_instr(4'h3);
        while (prog.size() > 6)
          void'(prog.pop_back());
        load_program(`IMEM_BYTES - 6);
        run_program(64'(`IMEM_BYTES - 6), `IMEM_BYTES - 6, 6, 1'b1);
      end
      else if (p == 2)
        run_program(64'(`IMEM_BYTES) + 64'(rand32() % 32'd4096), 0, 1, 1'b0);
      else
      begin
        build_random_program();
        base = int'(rand32() % 32'(`IMEM_BYTES - 140));
        load_program(base);
        run_program(64'(base), base, prog.size(), 1'b1);
      end
    end
    repeat (4) @(negedge clk);
    $display("records checked %0d, value errors %0d, strobe errors %0d",
             rec_count, value_errs, strobe_errs);
    if (rec_count == 0)
      $display("no fetch records were seen during the run");
    if (value_errs == 0 && strobe_errs == 0 && rec_count > 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // bound on the whole run
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the fetch runs did not finish", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/y86_pkg.sv
src/instr_mem.sv
src/instr_decode.sv
src/fetch_control.sv
src/y86_fetch_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv
